// File: execPkg.sv
////////////////////////////////////////////////////////////
// Shared widths, opcodes and instruction layout for the
// execute slice, referenced as execPkg::name everywhere
////////////////////////////////////////////////////////////
package execPkg;

  localparam int dataW = 16;                 // Data word width
  localparam int regW  = 4;                  // Register index width

  // Opcodes, values 10 to 15 are unused and retire nothing
  localparam logic [3:0] opAdd  = 4'd0;      // rd = rs + rt
  localparam logic [3:0] opSub  = 4'd1;      // rd = rs - rt
  localparam logic [3:0] opAnd  = 4'd2;      // Bitwise and
  localparam logic [3:0] opOr   = 4'd3;      // Bitwise or
  localparam logic [3:0] opXor  = 4'd4;      // Bitwise xor
  localparam logic [3:0] opSll  = 4'd5;      // Shift left logical
  localparam logic [3:0] opSrl  = 4'd6;      // Shift right logical
  localparam logic [3:0] opSra  = 4'd7;      // Shift right arithmetic
  localparam logic [3:0] opAddi = 4'd8;      // rd = rd + sext(imm8)
  localparam logic [3:0] opLli  = 4'd9;      // rd = sext(imm8)

  // Forwarding selector encoding
  localparam logic [1:0] fwdReg   = 2'b00;   // Value read at acceptance
  localparam logic [1:0] fwdExMem = 2'b10;   // Result one instruction ahead
  localparam logic [1:0] fwdMemWb = 2'b01;   // Result two instructions ahead

  ////////////////////////////////////////////////////////////
  // Instruction word, same bits seen as R-type or I-type
  ////////////////////////////////////////////////////////////
  typedef union packed {
    struct packed {
      logic [3:0] opcode;                    // Operation
      logic [3:0] rd;                        // Destination
      logic [3:0] rs;                        // Source A
      logic [3:0] rt;                        // Source B
    } r;
    struct packed {
      logic [3:0] opcode;                    // Operation
      logic [3:0] rd;                        // Destination, also source for addi
      logic [7:0] imm8;                      // Signed immediate
    } i;
  } instrWord_u;

endpackage

// File: regFile.sv
////////////////////////////////////////////////////////////
// Sixteen-entry register file, two async reads, one write
// A same-cycle write is bypassed to both read ports
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module regFile (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [execPkg::regW-1:0]   rdAddrA,   // Read port A address
  input  logic [execPkg::regW-1:0]   rdAddrB,   // Read port B address
  input  logic                       wrEn,      // Retiring result write
  input  logic [execPkg::regW-1:0]   wrAddr,
  input  logic [execPkg::dataW-1:0]  wrData,
  output logic [execPkg::dataW-1:0]  rdDataA,
  output logic [execPkg::dataW-1:0]  rdDataB
);

  logic [execPkg::dataW-1:0] regs [16];      // Architectural registers

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < 16; k++) begin
        regs[k] <= '0;                       // All registers start at zero
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Write-through so an instruction accepted on the retire edge sees the result
  assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
  assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// File: alu.sv
////////////////////////////////////////////////////////////
// Combinational ALU, result plus raw Z/N/V conditions
// The execute stage decides which flags actually latch
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu (
  input  logic [execPkg::dataW-1:0]  a,
  input  logic [execPkg::dataW-1:0]  b,
  input  logic [3:0]                 op,
  output logic [execPkg::dataW-1:0]  y,
  output logic                       zSet,     // Result is zero
  output logic                       nSet,     // Result is negative
  output logic                       vSet      // Signed overflow
);

  logic [3:0] shAmt;                         // Shift distance

  assign shAmt = b[3:0];                     // Only low 4 bits count

  always_comb begin
    y    = '0;                               // Unused opcodes give zero
    vSet = 1'b0;
    case (op)
      execPkg::opAdd, execPkg::opAddi: begin
        y    = a + b;                        // Wraps
        vSet = (a[15] == b[15]) && (y[15] != a[15]);
      end
      execPkg::opSub: begin
        y    = a - b;
        vSet = (a[15] != b[15]) && (y[15] != a[15]);
      end
      execPkg::opAnd: begin
        y = a & b;
      end
      execPkg::opOr: begin
        y = a | b;
      end
      execPkg::opXor: begin
        y = a ^ b;
      end
      execPkg::opSll: begin
        y = a << shAmt;
      end
      execPkg::opSrl: begin
        y = a >> shAmt;
      end
      execPkg::opSra: begin
        y = $signed(a) >>> shAmt;            // Sign bit fills from the left
      end
      execPkg::opLli: begin
        y = b;                               // Immediate passes through
      end
      default: begin
        y = '0;
      end
    endcase
  end

  assign zSet = (y == '0);
  assign nSet = y[15];

endmodule

// File: execStage.sv
////////////////////////////////////////////////////////////
// Execute datapath: operand latches, forwarding muxes, ALU,
// flag register and the EX/MEM and MEM/WB result latches
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execStage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       advance,  // Whole pipeline moves
  input  logic                       exValid,  // ID/EX holds an instruction
  input  logic [execPkg::dataW-1:0]  rdDataA,
  input  logic [execPkg::dataW-1:0]  rdDataB,
  input  logic [1:0]                 fwdA,
  input  logic [1:0]                 fwdB,
  input  logic [3:0]                 aluOp,
  input  logic                       useImm,   // Second operand is immediate
  input  logic [execPkg::dataW-1:0]  immExt,
  input  logic                       zEn,
  input  logic                       nvEn,
  output logic [execPkg::dataW-1:0]  outData,  // MEM/WB result
  output logic                       zf,
  output logic                       nf,
  output logic                       vf
);

  logic [execPkg::dataW-1:0] opA, opB;       // ID/EX operand latches
  logic [execPkg::dataW-1:0] srcA, srcB;     // After forwarding
  logic [execPkg::dataW-1:0] aluB;           // After immediate select
  logic [execPkg::dataW-1:0] aluY;
  logic [execPkg::dataW-1:0] emResult;       // EX/MEM result
  logic [execPkg::dataW-1:0] mwResult;       // MEM/WB result
  logic zSet, nSet, vSet;

  ////////////////////////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////////////////////////
  assign srcA = (fwdA == execPkg::fwdExMem) ? emResult :   // Nearest producer wins
                (fwdA == execPkg::fwdMemWb) ? mwResult :
                opA;
  assign srcB = (fwdB == execPkg::fwdExMem) ? emResult :
                (fwdB == execPkg::fwdMemWb) ? mwResult :
                opB;
  assign aluB = useImm ? immExt : srcB;

  alu alu_i (.a(srcA), .b(aluB), .op(aluOp), .y(aluY),
             .zSet(zSet), .nSet(nSet), .vSet(vSet));

  ////////////////////////////////////////////////////////////
  // Pipeline registers, payload only
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (advance) begin
      opA      <= rdDataA;                   // Register values at acceptance
      opB      <= rdDataB;
      emResult <= aluY;
      mwResult <= emResult;                  // MEM only carries the result
    end
  end

  // Flags latch with EX/MEM, each group under its own enable
  always_ff @(posedge clk) begin
    if (rst) begin
      zf <= 1'b0;
      nf <= 1'b0;
      vf <= 1'b0;
    end else if (advance && exValid) begin
      if (zEn) zf <= zSet;
      if (nvEn) begin
        nf <= nSet;
        vf <= vSet;
      end
    end
  end

  assign outData = mwResult;

endmodule

// File: execCtrl.sv
////////////////////////////////////////////////////////////
// Pipeline control: decode, per-stage valid/destination,
// forwarding selection and the advance/retire handshake
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execCtrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       inValid,
  input  logic [15:0]                inInstr,
  input  logic                       outReady,
  output logic                       inReady,
  output logic                       outValid,
  output logic [execPkg::regW-1:0]   outReg,
  output logic                       advance,
  output logic [execPkg::regW-1:0]   rdAddrA,
  output logic [execPkg::regW-1:0]   rdAddrB,
  output logic [1:0]                 fwdA,
  output logic [1:0]                 fwdB,
  output logic [3:0]                 aluOp,     // ID/EX latched
  output logic                       useImm,
  output logic [execPkg::dataW-1:0]  immExt,
  output logic                       zEn,
  output logic                       nvEn,
  output logic                       exValid,
  output logic                       wrEn       // Register file write on retire
);

  execPkg::instrWord_u dec;
  logic [3:0] opc;
  logic decWr, decUseA, decUseB, decImm, decZEn, decNvEn;
  logic idValid, idWr, idUseA, idUseB;       // ID/EX control
  logic [execPkg::regW-1:0] idRd, idSrcA, idSrcB;
  logic emValid, emWr;                       // EX/MEM control
  logic [execPkg::regW-1:0] emRd;
  logic mwValid, mwWr;                       // MEM/WB control
  logic [execPkg::regW-1:0] mwRd;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////
  assign dec = inInstr;
  assign opc = dec.r.opcode;

  always_comb begin
    decWr   = (opc <= execPkg::opLli);       // Opcodes 10..15 are bubbles
    decUseA = 1'b0;
    decUseB = 1'b0;
    decImm  = 1'b0;
    decZEn  = 1'b0;
    decNvEn = 1'b0;
    rdAddrA = dec.r.rs;
    rdAddrB = dec.r.rt;
    case (opc)
      execPkg::opAdd, execPkg::opSub: begin
        {decUseA, decUseB, decZEn, decNvEn} = 4'b1111;
      end
      execPkg::opAnd, execPkg::opOr, execPkg::opXor,
      execPkg::opSll, execPkg::opSrl, execPkg::opSra: begin
        {decUseA, decUseB, decZEn} = 3'b111; // Z only
      end
      execPkg::opAddi: begin
        rdAddrA = dec.i.rd;                  // Destination is also source
        {decUseA, decImm, decZEn, decNvEn} = 4'b1111;
      end
      execPkg::opLli: begin
        decImm = 1'b1;                       // No source, no flags
      end
      default: begin
        decWr = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Handshake and stage tracking
  ////////////////////////////////////////////////////////////
  assign outValid = mwValid & mwWr;
  assign advance  = ~outValid | outReady;    // MEM/WB empty or draining
  assign inReady  = advance;
  assign wrEn     = outValid & outReady;
  assign outReg   = mwRd;
  assign exValid  = idValid;

  always_ff @(posedge clk) begin
    if (rst) begin
      {idValid, emValid, mwValid} <= 3'b000;
      {idWr, emWr, mwWr} <= 3'b000;
    end else if (advance) begin
      idValid <= inValid;
      idWr    <= decWr;
      emValid <= idValid;
      emWr    <= idWr;
      mwValid <= emValid;
      mwWr    <= emWr;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      {idUseA, idUseB, useImm, zEn, nvEn} <= {decUseA, decUseB, decImm, decZEn, decNvEn};
      aluOp  <= opc;
      immExt <= {{8{dec.i.imm8[7]}}, dec.i.imm8};
      idRd   <= dec.r.rd;
      idSrcA <= rdAddrA;
      idSrcB <= rdAddrB;
      emRd   <= idRd;
      mwRd   <= emRd;
    end
  end

  // EX/MEM first, then MEM/WB, else the latched register value
  function automatic logic [1:0] fwdSel(input logic srcUsed,
                                        input logic [execPkg::regW-1:0] src);
    if (srcUsed && emValid && emWr && emRd == src) return execPkg::fwdExMem;
    if (srcUsed && mwValid && mwWr && mwRd == src) return execPkg::fwdMemWb;
    return execPkg::fwdReg;
  endfunction

  always_comb begin
    fwdA = fwdSel(idUseA, idSrcA);
    fwdB = fwdSel(idUseB, idSrcB);
  end

endmodule

// File: execTop.sv
////////////////////////////////////////////////////////////
// Top level of the execute slice, control plus datapath
// Instructions in on a valid/ready port, results out on one
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execTop (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       inValid,
  input  logic [15:0]                inInstr,
  input  logic                       outReady,
  output logic                       inReady,
  output logic                       outValid,
  output logic [execPkg::regW-1:0]   outReg,   // Retiring destination
  output logic [execPkg::dataW-1:0]  outData,  // Retiring value
  output logic                       zf,
  output logic                       nf,
  output logic                       vf
);

  logic                      advance, exValid, wrEn;
  logic [execPkg::regW-1:0]  rdAddrA, rdAddrB;
  logic [execPkg::dataW-1:0] rdDataA, rdDataB;
  logic [1:0]                fwdA, fwdB;
  logic [3:0]                aluOp;
  logic                      useImm, zEn, nvEn;
  logic [execPkg::dataW-1:0] immExt;

  execCtrl execCtrl_i (
    .clk(clk), .rst(rst),
    .inValid(inValid), .inInstr(inInstr), .outReady(outReady),
    .inReady(inReady), .outValid(outValid), .outReg(outReg),
    .advance(advance), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
    .fwdA(fwdA), .fwdB(fwdB), .aluOp(aluOp), .useImm(useImm),
    .immExt(immExt), .zEn(zEn), .nvEn(nvEn),
    .exValid(exValid), .wrEn(wrEn)
  );

  regFile regFile_i (                        // Written by the retiring result
    .clk(clk), .rst(rst),
    .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
    .wrEn(wrEn), .wrAddr(outReg), .wrData(outData),
    .rdDataA(rdDataA), .rdDataB(rdDataB)
  );

  execStage execStage_i (
    .clk(clk), .rst(rst), .advance(advance), .exValid(exValid),
    .rdDataA(rdDataA), .rdDataB(rdDataB), .fwdA(fwdA), .fwdB(fwdB),
    .aluOp(aluOp), .useImm(useImm), .immExt(immExt),
    .zEn(zEn), .nvEn(nvEn),
    .outData(outData), .zf(zf), .nf(nf), .vf(vf)
  );

endmodule

// File: execTop_props.sv
////////////////////////////////////////////////////////////
// Handshake and reset properties, bound into execTop
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execTop_props (
  input logic                       clk,
  input logic                       rst,
  input logic                       inReady,
  input logic                       outValid,
  input logic                       outReady,
  input logic [execPkg::regW-1:0]   outReg,
  input logic [execPkg::dataW-1:0]  outData,
  input logic                       zf,
  input logic                       nf,
  input logic                       vf
);

  // Output port is empty right after reset
  resetEmpty: assert property (@(posedge clk) rst |=> !outValid)
    else $error("outValid high in the cycle after reset");

  // Stalled result and flags do not move
  stallHold: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outReg) && $stable(outData)
                                 && $stable({zf, nf, vf})))
    else $error("output or flags changed while stalled");

  // Input stalls only behind a blocked result
  readyRule: assert property (@(posedge clk) disable iff (rst)
    !inReady |-> (outValid && !outReady))
    else $error("inReady low without output back-pressure");

endmodule

// File: tb_execTop.sv
////////////////////////////////////////////////////////////
// Directed testbench for the execute slice, checks every
// retired result and the flags against a program-order model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_execTop;

  logic clk, rst, inValid, outReady;
  logic [15:0] inInstr;
  logic inReady, outValid, zf, nf, vf;
  logic [3:0] outReg;
  logic [15:0] outData;

  logic [15:0] mRegs [16];                   // Model registers
  logic mZ, mN, mV;                          // Model flags
  logic [19:0] expQ [$];                     // Expected {reg, value} in order
  logic [31:0] lfsrState;
  logic [15:0] pendInstr;                    // Word offered on the input
  logic pendValid, randReady;
  int idle;                                  // Cycles since last acceptance

  execTop dut_i (.clk(clk), .rst(rst), .inValid(inValid), .inInstr(inInstr),
                 .outReady(outReady), .inReady(inReady), .outValid(outValid),
                 .outReg(outReg), .outData(outData), .zf(zf), .nf(nf), .vf(vf));

  bind execTop execTop_props props_i (.clk(clk), .rst(rst), .inReady(inReady),
    .outValid(outValid), .outReady(outReady), .outReg(outReg), .outData(outData),
    .zf(zf), .nf(nf), .vf(vf));

  always #2 clk = ~clk;                      // 4 ns period

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  task automatic failNow(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) failNow($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  function automatic logic lfsrBit();
    logic b;
    b = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (b) lfsrState = lfsrState ^ 32'h8020_0003; // Galois taps
    return b;
  endfunction

  function automatic logic [15:0] randBits(input int n);
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[14:0], lfsrBit()};
    return v;
  endfunction

  function automatic logic [15:0] rType(input logic [3:0] op, rd, rs, rt);
    execPkg::instrWord_u w;
    w.r.opcode = op;
    w.r.rd = rd;
    w.r.rs = rs;
    w.r.rt = rt;
    return w;
  endfunction

  function automatic logic [15:0] iType(input logic [3:0] op, rd, input logic [7:0] imm);
    execPkg::instrWord_u w;
    w.i.opcode = op;
    w.i.rd = rd;
    w.i.imm8 = imm;
    return w;
  endfunction

  // Signed add or subtract, overflow when outside the 16-bit range
  function automatic logic [16:0] addOvf(input logic [15:0] a, b, input logic sub);
    int r;
    r = int'($signed(a)) + (sub ? -int'($signed(b)) : int'($signed(b)));
    return {(r > 32767 || r < -32768), r[15:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model, run in program order at acceptance
  ////////////////////////////////////////////////////////////
  task automatic modelExec(input logic [15:0] word);
    execPkg::instrWord_u u;
    logic [15:0] a, b, imm, y;
    logic [16:0] r;
    int kind;                                // 0 no flags, 1 Z only, 2 all
    u = word;
    a = mRegs[u.r.rs];
    b = mRegs[u.r.rt];
    imm = 16'($signed(u.i.imm8));            // Sign-extended immediate
    r = '0;
    kind = 1;
    case (u.r.opcode)
      execPkg::opAdd: begin
        r = addOvf(a, b, 1'b0);
        kind = 2;
      end
      execPkg::opSub: begin
        r = addOvf(a, b, 1'b1);
        kind = 2;
      end
      execPkg::opAnd: r[15:0] = a & b;
      execPkg::opOr:  r[15:0] = a | b;
      execPkg::opXor: r[15:0] = a ^ b;
      execPkg::opSll: r[15:0] = a << b[3:0];
      execPkg::opSrl: r[15:0] = a >> b[3:0];
      execPkg::opSra: r[15:0] = $signed(a) >>> b[3:0];
      execPkg::opAddi: begin
        r = addOvf(mRegs[u.i.rd], imm, 1'b0);
        kind = 2;
      end
      default: begin
        r[15:0] = imm;
        kind = 0;
      end
    endcase
    y = r[15:0];
    if (u.r.opcode <= execPkg::opLli) begin  // Higher opcodes are bubbles
      if (kind != 0) mZ = (y == 16'h0);
      if (kind == 2) begin
        mN = y[15];
        mV = r[16];
      end
      mRegs[u.r.rd] = y;
      expQ.push_back({u.r.rd, y});
    end
  endtask

  task automatic checkOut();
    logic [19:0] e;
    if (expQ.size() == 0) failNow("a result retired with nothing expected");
    else begin
      e = expQ.pop_front();
      compare("outReg", 16'(outReg), 16'(e[19:16]));
      compare("outData", outData, e[15:0]);
    end
  endtask

  // One cycle: drive on the falling edge, judge the coming rising edge
  task automatic step();
    @(negedge clk);
    outReady = randReady ? lfsrBit() : 1'b1;
    inValid = pendValid;
    inInstr = pendInstr;
    #1;
    idle++;
    if (outValid && outReady) checkOut();
    if (inValid && inReady) begin
      modelExec(pendInstr);
      pendValid = 1'b0;
      idle = 0;
    end
  endtask

  task automatic issue(input logic [15:0] w);
    int n;
    pendInstr = w;
    pendValid = 1'b1;
    n = 0;
    while (pendValid) begin
      if (n == 200) failNow("input handshake timed out");
      else begin
        step();
        n++;
      end
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (expQ.size() != 0 || idle < 4) begin   // Flags settle 2 edges after accept
      if (n == 300) failNow("pipeline did not drain");
      else begin
        step();
        n++;
      end
    end
  endtask

  task automatic checkFlags();
    compare("zf", 16'(zf), 16'(mZ));
    compare("nf", 16'(nf), 16'(mN));
    compare("vf", 16'(vf), 16'(mV));
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic testReset();
    @(negedge clk);
    #1;
    compare("outValid", 16'(outValid), 16'h0);
    compare("inReady", 16'(inReady), 16'h1);
    checkFlags();                            // Model flags are all zero here
  endtask

  task automatic testOpcodes();
    issue(iType(execPkg::opLli, 4'd1, 8'h35));
    issue(iType(execPkg::opLli, 4'd2, 8'hFD));
    issue(iType(execPkg::opLli, 4'd3, 8'h05));
    issue(iType(execPkg::opLli, 4'd12, 8'h40));
    drain();
    for (int k = 0; k < 8; k++) begin        // Shifts take r2 by r3
      issue(rType(4'(k), 4'(k + 4), (k >= 5) ? 4'd2 : 4'd1, (k >= 5) ? 4'd3 : 4'd2));
    end
    issue(iType(execPkg::opAddi, 4'd12, 8'h9C));
    drain();
  endtask

  task automatic testChains();
    issue(iType(execPkg::opLli, 4'd1, 8'h03));
    issue(rType(execPkg::opAdd, 4'd2, 4'd1, 4'd1));   // Distance 1
    issue(rType(execPkg::opSub, 4'd3, 4'd2, 4'd1));   // Distance 1 and 2
    issue(rType(execPkg::opXor, 4'd4, 4'd1, 4'd3));   // Distance 3 via bypass
    issue(rType(execPkg::opAdd, 4'd5, 4'd2, 4'd2));
    issue(iType(execPkg::opAddi, 4'd5, 8'hF9));
    issue(rType(execPkg::opOr, 4'd6, 4'd4, 4'd5));
    issue(iType(execPkg::opLli, 4'd7, 8'h01));
    issue(rType(execPkg::opAdd, 4'd7, 4'd7, 4'd7));   // Both stages hold r7
    issue(rType(execPkg::opAdd, 4'd7, 4'd7, 4'd7));
    drain();
  endtask

  task automatic testFlags();
    issue(iType(execPkg::opLli, 4'd1, 8'hFF));
    issue(iType(execPkg::opLli, 4'd2, 8'h01));
    issue(rType(execPkg::opSrl, 4'd1, 4'd1, 4'd2));   // 0x7FFF
    issue(rType(execPkg::opAdd, 4'd3, 4'd1, 4'd2));   // Overflow
    drain();
    checkFlags();
    issue(rType(execPkg::opAnd, 4'd7, 4'd1, 4'd3));   // Z set, N and V kept
    drain();
    checkFlags();
    issue(iType(execPkg::opLli, 4'd8, 8'h01));        // Would clear Z, N and V
    for (int k = 10; k < 16; k++) issue(rType(4'(k), 4'd9, 4'd1, 4'd2));
    drain();
    checkFlags();
    issue(rType(execPkg::opSub, 4'd4, 4'd1, 4'd1));   // Zero
    drain();
    checkFlags();
    issue(iType(execPkg::opLli, 4'd5, 8'hFB));
    issue(rType(execPkg::opAdd, 4'd6, 4'd5, 4'd2));   // Negative
    drain();
    checkFlags();
  endtask

  task automatic testStream();
    randReady = 1'b1;
    for (int k = 0; k < 40; k++) begin
      if (lfsrBit()) step();                 // Random input gap
      issue(randBits(16));
    end
    drain();
    randReady = 1'b0;
    issue(rType(execPkg::opSub, 4'd0, 4'd0, 4'd0));  // r0 becomes zero
    for (int k = 1; k < 16; k++) issue(rType(execPkg::opAdd, 4'(k), 4'(k), 4'd0));
    drain();
    checkFlags();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = 1'b0;
    inInstr = '0;
    outReady = 1'b1;
    pendValid = 1'b0;
    pendInstr = '0;
    randReady = 1'b0;
    idle = 0;
    lfsrState = 32'd91337;
    {mZ, mN, mV} = 3'b000;
    for (int k = 0; k < 16; k++) mRegs[k] = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    testReset();
    testOpcodes();
    testChains();
    testFlags();
    testStream();
    if (expQ.size() != 0) failNow("results still expected at the end");
    else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// File: sources.f
execPkg.sv
regFile.sv
alu.sv
execStage.sv
execCtrl.sv
execTop.sv
execTop_props.sv
tb_execTop.sv

// File: Makefile
# Verilator build and run of the execute slice testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module tb_execTop -o simv
	@out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f sources.f \
		--top-module execTop

clean:
	rm -rf obj_dir
